//--- verification/gameControlTests.txt
// key hold wait score next, then the board as ten 20-bit hex fields
// from rows 19/18 down to rows 1/0, odd row in the upper ten bits
0 1 0 00 1 00000 00000 00000 00000 00000 00000 00000 00000 00000 1e000
1 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 00000 0f000
1 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 00000 07800
1 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 00000 03c00
1 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 00000 03c00
3 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 00000 03c00
0 1 13 00 1 00000 00000 00000 00000 00000 00000 00000 00000 0000f 00000
2 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 0001e 00000
2 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 0003c 00000
2 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 00078 00000
2 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 000f0 00000
2 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 001e0 00000
0 1 7 00 1 00000 00000 00000 00000 00000 00000 00000 00000 78000 00000
2 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 f0000 00000
2 1 5 00 1 00000 00000 00000 00000 00000 00000 00000 00000 f0000 00000
0 1 320 01 2 f0000 00000 00000 00000 00000 00000 00000 00000 00000 18060
1 1 5 01 2 f0000 00000 00000 00000 00000 00000 00000 00000 00000 0c030
1 1 5 01 2 f0000 00000 00000 00000 00000 00000 00000 00000 00000 06018
0 1 380 02 3 f6018 00000 00000 00000 00000 00000 00000 00000 00000 1c020
1 1 5 02 3 f6018 00000 00000 00000 00000 00000 00000 00000 00000 0e010
1 1 5 02 3 f6018 00000 00000 00000 00000 00000 00000 00000 00000 07008
1 1 5 02 3 f6018 00000 00000 00000 00000 00000 00000 00000 00000 03804
1 1 5 02 3 f6018 00000 00000 00000 00000 00000 00000 00000 00000 01c02
0 1 372 03 4 f7c1a 00000 00000 00000 00000 00000 00000 00000 00000 1c040
3 1 5 03 4 f7c1a 00000 00000 00000 00000 00000 00000 00000 00060 08020
3 1 5 03 4 f7c1a 00000 00000 00000 00000 00000 00000 00000 00010 1c000
3 1 5 03 4 f7c1a 00000 00000 00000 00000 00000 00000 00000 00020 08030
0 1 349 0e 0 0e830 00000 00000 00000 00000 00000 00000 00000 00000 0c060

//--- verilog.f
verilog/tetrisPkg.sv
verilog/moveRequest.sv
verilog/collisionCheck.sv
verilog/boardStore.sv
verilog/gameControl.sv
verification/gameControlTb.sv

//--- Bender.yml
package:
  name: game_control

sources:
  - verilog/tetrisPkg.sv
  - verilog/moveRequest.sv
  - verilog/collisionCheck.sv
  - verilog/boardStore.sv
  - verilog/gameControl.sv
  - target: test
    files:
      - verification/gameControlTb.sv

//--- verification/gameControlTb.sv
`timescale 1ns/10ps

module gameControlTb;
    import tetrisPkg::*;

    localparam int TickCycles = 48;
    localparam int MaxTests = 64;
    localparam int ClockNs = 40;

    logic clk;
    logic rstReg;
    keyCode_t keyboardSignal;
    logic [6:0] score;
    pieceType_t nextBlock;
    board_t objects;

    logic [1:0] keyList [MaxTests];
    int holdList [MaxTests];
    int waitList [MaxTests];
    logic [6:0] scoreList [MaxTests];
    pieceType_t nextList [MaxTests];
    board_t boardList [MaxTests];
    int testCount;
    int passCount;
    int failCount;
    int limitCycles;

    gameControl #(
        .TickCycles(TickCycles)
    ) i_dut (
        .clk           (clk),
        .rstReg        (rstReg),
        .keyboardSignal(keyboardSignal),
        .score         (score),
        .nextBlock     (nextBlock),
        .objects       (objects)
    );

    always #(ClockNs / 2) clk = ~clk;

    // ####################
    // Test file
    // ####################
    task automatic loadTests();
        int fd;
        int n;
        logic [8*256-1:0] textLine;
        logic [31:0] k, h, w, s, nb;
        logic [19:0] pr [10];
        fd = $fopen("verification/gameControlTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file");
            failCount++;
            return;
        end
        while (!$feof(fd) && testCount < MaxTests) begin
            textLine = '0;
            if ($fgets(textLine, fd) != 0) begin
                n = $sscanf(textLine, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    k, h, w, s, nb, pr[9], pr[8], pr[7], pr[6], pr[5],
                    pr[4], pr[3], pr[2], pr[1], pr[0]);
                if (n == 15) begin
                    keyList[testCount] = k[1:0];
                    holdList[testCount] = h;
                    waitList[testCount] = w;
                    scoreList[testCount] = s[6:0];
                    nextList[testCount] = nb[2:0];
                    // Each field holds an odd row above the even row below it
                    for (int i = 0; i < 10; i++) begin
                        boardList[testCount][i*20 +: 20] = pr[i];
                    end
                    testCount++;
                end else if (n > 0) begin
                    $display("Malformed line in the test file after test %0d", testCount);
                    failCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic runTest(input int t);
        int errs;
        errs = 0;
        @(posedge clk);
        keyboardSignal <= keyCode_t'(keyList[t]);
        repeat (holdList[t]) @(posedge clk);
        keyboardSignal <= KeyIdle;
        repeat (waitList[t]) @(posedge clk);
        @(negedge clk);
        assert (score === scoreList[t]) else begin
            $display("MISMATCH at %0t: score got %h expected %h", $time, score, scoreList[t]);
            errs++;
        end
        assert (nextBlock === nextList[t]) else begin
            $display("MISMATCH at %0t: nextBlock got %h expected %h",
                $time, nextBlock, nextList[t]);
            errs++;
        end
        assert (objects === boardList[t]) else begin
            $display("MISMATCH at %0t: objects got %h expected %h",
                $time, objects, boardList[t]);
            errs++;
        end
        if (errs == 0) begin
            passCount++;
            $display("test %0d: pass", t);
        end else begin
            failCount++;
            $display("test %0d: fail", t);
        end
    endtask

    // ####################
    // Main sequence
    // ####################
    initial begin
        int total;
        clk = 1'b0;
        rstReg = 1'b1;
        keyboardSignal = KeyIdle;
        testCount = 0;
        passCount = 0;
        failCount = 0;
        limitCycles = 0;
        loadTests();
        total = 2;
        for (int t = 0; t < testCount; t++) begin
            total += holdList[t] + waitList[t] + 1;
        end
        limitCycles = total + 100;
        repeat (2) @(posedge clk);
        rstReg <= 1'b0;
        for (int t = 0; t < testCount; t++) begin
            runTest(t);
        end
        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0 && testCount > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limitCycles > 0);
        #(limitCycles * ClockNs);
        $display("Run did not finish within %0d cycles", limitCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verilog/gameControl.sv
`timescale 1ns/10ps

module gameControl #(
    parameter int TickCycles = 2 ** 25
) (
    input  logic                  clk,
    input  logic                  rstReg,
    input  tetrisPkg::keyCode_t   keyboardSignal,
    output logic [6:0]            score,
    output tetrisPkg::pieceType_t nextBlock,
    output tetrisPkg::board_t     objects
);
    import tetrisPkg::*;

    piece_t activePiece;
    moveAction_t action;
    verdict_t verdict;
    board_t settled;

    // Keys and gravity to candidate moves
    moveRequest #(
        .TickCycles(TickCycles)
    ) requestStage (
        .clk           (clk),
        .rstReg        (rstReg),
        .keyboardSignal(keyboardSignal),
        .activePiece   (activePiece),
        .action        (action)
    );

    collisionCheck checkStage (
        .clk    (clk),
        .rstReg (rstReg),
        .action (action),
        .settled(settled),
        .verdict(verdict)
    );

    boardStore storeStage (
        .clk        (clk),
        .rstReg     (rstReg),
        .verdict    (verdict),
        .activePiece(activePiece),
        .settled    (settled),
        .score      (score),
        .nextBlock  (nextBlock),
        .objects    (objects)
    );

endmodule

//--- verilog/boardStore.sv
`timescale 1ns/10ps

module boardStore (
    input  logic                 clk,
    input  logic                 rstReg,
    input  tetrisPkg::verdict_t  verdict,
    output tetrisPkg::piece_t    activePiece,
    output tetrisPkg::board_t    settled,
    output logic [6:0]           score,
    output tetrisPkg::pieceType_t nextBlock,
    output tetrisPkg::board_t    objects
);
    import tetrisPkg::*;

    board_t settledReg;
    board_t activeMask;
    piece_t activeReg;
    pieceType_t nextReg;
    logic [6:0] scoreReg;

    board_t merged;
    board_t compacted;
    logic [4:0] clearedRows;
    logic [6:0] scoreGain;
    piece_t spawnNext;

    function automatic board_t cellMask(input cellSet_t cells);
        board_t mask;
        mask = '0;
        for (int i = 0; i < 4; i++) begin
            mask[int'(cells[i].row) * BoardCols + int'(cells[i].col)] = 1'b1;
        end
        return mask;
    endfunction

    function automatic piece_t spawnPiece(input pieceType_t shape);
        piece_t p;
        p.shape = shape;
        p.rot = '0;
        p.row = row_t'(SpawnRow);
        p.col = col_t'(SpawnCol);
        return p;
    endfunction

    // ####################
    // Lock and row clear
    // ####################
    assign merged = settledReg | activeMask;

    // Walk up from the bottom, copying only rows that are not full
    always_comb begin
        int dst;
        compacted = '0;
        clearedRows = '0;
        dst = BoardRows - 1;
        for (int r = BoardRows - 1; r >= 0; r--) begin
            if (&merged[r*BoardCols +: BoardCols]) begin
                clearedRows = clearedRows + 1'b1;
            end else begin
                compacted[dst*BoardCols +: BoardCols] = merged[r*BoardCols +: BoardCols];
                dst = dst - 1;
            end
        end
    end

    assign scoreGain = 7'(1 + 10 * clearedRows);
    assign spawnNext = spawnPiece(nextReg);

    always_ff @(posedge clk) begin
        if (rstReg) begin
            settledReg <= '0;
            activeReg <= spawnPiece(3'd0);
            activeMask <= cellMask(pieceCells(spawnPiece(3'd0)));
            scoreReg <= '0;
            nextReg <= 3'd1;
        end else if (verdict.valid && verdict.lock) begin
            settledReg <= compacted;
            scoreReg <= scoreReg + scoreGain;
            activeReg <= spawnNext;
            activeMask <= cellMask(pieceCells(spawnNext));
            // Fixed cycle through the piece types
            nextReg <= (nextReg == 3'(PieceCount - 1)) ? 3'd0 : nextReg + 1'b1;
        end else if (verdict.valid && verdict.accept) begin
            activeReg <= verdict.piece;
            activeMask <= cellMask(verdict.cells);
        end
    end

    // ####################
    // Outputs
    // ####################
    assign activePiece = activeReg;
    assign settled = settledReg;
    assign score = scoreReg;
    assign nextBlock = nextReg;
    assign objects = settledReg | activeMask;

endmodule

//--- verilog/collisionCheck.sv
`timescale 1ns/10ps

module collisionCheck (
    input  logic                   clk,
    input  logic                   rstReg,
    input  tetrisPkg::moveAction_t action,
    input  tetrisPkg::board_t      settled,
    output tetrisPkg::verdict_t    verdict
);
    import tetrisPkg::*;

    shapedMove_t shaped;
    logic blocked;

    function automatic logic cellBlocked(input cell_t c, input board_t b);
        int idx;
        if (c.row < 0 || c.row >= BoardRows) begin
            return 1'b1;
        end
        if (c.col < 0 || c.col >= BoardCols) begin
            return 1'b1;
        end
        idx = int'(c.row) * BoardCols + int'(c.col);
        return b[idx];
    endfunction

    // ####################
    // Shape expansion
    // ####################
    always_ff @(posedge clk) begin
        if (rstReg) begin
            shaped <= '0;
        end else begin
            shaped.act <= action;
            shaped.cells <= pieceCells(action.piece);
        end
    end

    // ####################
    // Border and board test
    // ####################
    always_comb begin
        blocked = 1'b0;
        for (int i = 0; i < 4; i++) begin
            blocked = blocked | cellBlocked(shaped.cells[i], settled);
        end
    end

    // Blocked drop means the piece has landed
    always_ff @(posedge clk) begin
        if (rstReg) begin
            verdict <= '0;
        end else begin
            verdict.valid <= shaped.act.valid;
            verdict.accept <= shaped.act.valid && !blocked;
            verdict.lock <= shaped.act.valid && blocked && (shaped.act.kind == MoveDrop);
            verdict.piece <= shaped.act.piece;
            verdict.cells <= shaped.cells;
        end
    end

endmodule

//--- verilog/moveRequest.sv
`timescale 1ns/10ps

module moveRequest #(
    parameter int TickCycles = 2 ** 25
) (
    input  logic                  clk,
    input  logic                  rstReg,
    input  tetrisPkg::keyCode_t   keyboardSignal,
    input  tetrisPkg::piece_t     activePiece,
    output tetrisPkg::moveAction_t action
);
    import tetrisPkg::*;

    localparam int CountWidth = (TickCycles > 1) ? $clog2(TickCycles) : 1;
    // Quiet cycles after an action, until its result is committed
    localparam int Gap = 3;

    keyCode_t prevKey;
    logic [CountWidth-1:0] tickCount;
    logic [1:0] busyCount;
    logic keyPending;
    logic dropPending;
    moveKind_t pendKind;
    moveKind_t keyKind;
    logic keyEvent;
    logic tick;

    function automatic piece_t stepPiece(input piece_t p, input moveKind_t k);
        piece_t n;
        n = p;
        case (k)
            MoveLeft: n.col = p.col - col_t'(1);
            MoveRight: n.col = p.col + col_t'(1);
            MoveRotate: n.rot = p.rot + rotation_t'(1);
            default: n.row = p.row + row_t'(1);
        endcase
        return n;
    endfunction

    assign keyEvent = (keyboardSignal != KeyIdle) && (keyboardSignal != prevKey);
    assign tick = (tickCount == CountWidth'(TickCycles - 1));

    always_comb begin
        case (keyboardSignal)
            KeyLeft: keyKind = MoveLeft;
            KeyRight: keyKind = MoveRight;
            default: keyKind = MoveRotate;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rstReg) begin
            prevKey <= KeyIdle;
            tickCount <= '0;
            busyCount <= '0;
            keyPending <= 1'b0;
            dropPending <= 1'b0;
            pendKind <= MoveLeft;
            action <= '0;
        end else begin
            prevKey <= keyboardSignal;
            tickCount <= tick ? '0 : tickCount + 1'b1;
            action.valid <= 1'b0;

            // Keys win over gravity
            if (busyCount != 0) begin
                busyCount <= busyCount - 1'b1;
            end else if (keyPending) begin
                action <= '{valid: 1'b1, kind: pendKind, piece: stepPiece(activePiece, pendKind)};
                keyPending <= 1'b0;
                busyCount <= 2'(Gap);
            end else if (dropPending) begin
                action <= '{valid: 1'b1, kind: MoveDrop, piece: stepPiece(activePiece, MoveDrop)};
                dropPending <= 1'b0;
                busyCount <= 2'(Gap);
            end

            // New events land after the issue so they are never lost
            if (keyEvent) begin
                keyPending <= 1'b1;
                pendKind <= keyKind;
            end
            if (tick) begin
                dropPending <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/tetrisPkg.sv
package tetrisPkg;

    // ####################
    // Board geometry
    // ####################
    localparam int BoardRows = 20;
    localparam int BoardCols = 10;
    localparam int BoardCells = BoardRows * BoardCols;
    localparam int SpawnCol = 5;
    localparam int SpawnRow = 1;
    localparam int PieceCount = 5;

    typedef enum logic [1:0] {KeyIdle, KeyLeft, KeyRight, KeyRotate} keyCode_t;
    typedef enum logic [1:0] {MoveLeft, MoveRight, MoveRotate, MoveDrop} moveKind_t;

    typedef logic [2:0] pieceType_t;
    typedef logic [1:0] rotation_t;
    // Signed so that cells off the board stay visible
    typedef logic signed [5:0] row_t;
    typedef logic signed [4:0] col_t;

    typedef logic [BoardCells-1:0] board_t;

    typedef struct packed {
        pieceType_t shape;
        rotation_t rot;
        row_t row;
        col_t col;
    } piece_t;

    typedef struct packed {
        row_t row;
        col_t col;
    } cell_t;

    typedef cell_t [3:0] cellSet_t;

    typedef struct packed {
        logic valid;
        moveKind_t kind;
        piece_t piece;
    } moveAction_t;

    typedef struct packed {
        moveAction_t act;
        cellSet_t cells;
    } shapedMove_t;

    typedef struct packed {
        logic valid;
        logic accept;
        logic lock;
        piece_t piece;
        cellSet_t cells;
    } verdict_t;

    // Fourth cell of T (0..3) and L (4..7), by rotation
    localparam row_t ExtraRow [8] = '{-1, 0, 1, 0, -1, 1, 1, -1};
    localparam col_t ExtraCol [8] = '{0, 1, 0, -1, 1, 1, -1, -1};

    function automatic cellSet_t pieceCells(input piece_t p);
        row_t dr [4];
        col_t dc [4];
        cellSet_t cells;
        case (p.shape)
            3'd0: begin
                dr = p.rot[0] ? '{-2, -1, 0, 1} : '{0, 0, 0, 0};
                dc = p.rot[0] ? '{0, 0, 0, 0} : '{-2, -1, 0, 1};
            end
            3'd1: begin
                dr = '{-1, -1, 0, 0};
                dc = '{0, 1, 0, 1};
            end
            3'd2, 3'd3: begin
                // Spine of three, then the odd cell
                dr = p.rot[0] ? '{-1, 0, 1, 0} : '{0, 0, 0, 0};
                dc = p.rot[0] ? '{0, 0, 0, 0} : '{-1, 0, 1, 0};
                dr[3] = ExtraRow[{p.shape[0], p.rot}];
                dc[3] = ExtraCol[{p.shape[0], p.rot}];
            end
            default: begin
                dr = p.rot[0] ? '{0, 0, -1, 1} : '{0, 0, -1, -1};
                dc = p.rot[0] ? '{-1, 0, -1, 0} : '{-1, 0, 0, 1};
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            cells[i].row = p.row + dr[i];
            cells[i].col = p.col + dc[i];
        end
        return cells;
    endfunction

endpackage
